// File: Makefile
TOP = mdu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// File: source/mdu_divider.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_divider import mdu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 kill_i,
    input  logic                 start_i,
    input  logic [`MDU_XLEN-1:0] a_i,
    input  logic [`MDU_XLEN-1:0] b_i,
    output logic                 done_o,
    output mdu_core_res_s        res_o
);
    localparam int CNT_W = $clog2(`MDU_STEPS);

    logic [`MDU_XLEN-1:0] rem_q;
    logic [`MDU_XLEN-1:0] quo_q;   // dividend bits shift out, quotient bits in
    logic [`MDU_XLEN-1:0] dvsr_q;
    logic [`MDU_XLEN:0]   shifted;
    logic [`MDU_XLEN+1:0] diff;
    logic [CNT_W-1:0]     cnt_q;
    logic                 busy_q;
    logic                 done_q;

    assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (kill_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`MDU_STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q  <= '0;
            quo_q  <= a_i;
            dvsr_q <= b_i;
        end else if (busy_q) begin
            if (!diff[`MDU_XLEN+1]) begin
                rem_q <= diff[`MDU_XLEN-1:0];          // fits since rem < divisor
                quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`MDU_XLEN-1:0];       // restore
                quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b0};
            end
        end
    end

    assign done_o   = done_q;
    assign res_o.hi = rem_q;
    assign res_o.lo = quo_q;

    // zero divisors are routed to the special path upstream
    a_nonzero_divisor: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> (b_i != '0))
        else $error("divider started with zero divisor");

endmodule

// File: source/mdu_multiplier.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_multiplier import mdu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 kill_i,
    input  logic                 start_i,
    input  logic [`MDU_XLEN-1:0] a_i,
    input  logic [`MDU_XLEN-1:0] b_i,
    output logic                 done_o,
    output mdu_core_res_s        res_o
);
    localparam int CNT_W = $clog2(`MDU_STEPS);

    logic [2*`MDU_XLEN-1:0] acc_q;
    logic [2*`MDU_XLEN-1:0] mcand_q;
    logic [`MDU_XLEN-1:0]   mplier_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   busy_q;
    logic                   done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (kill_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`MDU_STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q    <= '0;
            mcand_q  <= {{`MDU_XLEN{1'b0}}, a_i};
            mplier_q <= b_i;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q; // add shifted multiplicand
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign done_o   = done_q;
    assign res_o.hi = acc_q[2*`MDU_XLEN-1:`MDU_XLEN];
    assign res_o.lo = acc_q[`MDU_XLEN-1:0];

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n_i)
        start_i |-> !busy_q)
        else $error("multiplier started while busy");

endmodule

// File: source/mdu_operand_prep.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_operand_prep import mdu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      start_i,
    input  logic      kill_i,
    input  logic      done_i,
    input  mdu_req_s  req_i,
    output logic      ready_o,
    output mdu_prep_s prep_o,
    output logic      mul_start_o,
    output logic      div_start_o,
    output logic      spec_o
);
    logic      busy_q;
    logic      accept;
    logic      sgn_a;
    logic      sgn_b;
    logic      neg_a;
    logic      neg_b;
    mdu_spec_e spec;
    mdu_prep_s prep_d;
    mdu_prep_s prep_q;
    logic      mul_start_q;
    logic      div_start_q;
    logic      spec_wait_q;
    logic      spec_q;

    assign ready_o = !busy_q && !kill_i;
    assign accept  = start_i && ready_o;

    always_comb begin
        if (req_i.op.div.is_div) begin
            sgn_a = !req_i.op.div.is_unsigned;
            sgn_b = !req_i.op.div.is_unsigned;
        end else begin
            sgn_a = (req_i.op.mul.mode == MULH) || (req_i.op.mul.mode == MULHSU);
            sgn_b = (req_i.op.mul.mode == MULH); // MUL low word is sign agnostic
        end
        neg_a = sgn_a && req_i.rs1[`MDU_XLEN-1];
        neg_b = sgn_b && req_i.rs2[`MDU_XLEN-1];

        spec = SPEC_NONE;
        if (req_i.op.div.is_div) begin
            if (req_i.rs2 == '0) begin
                spec = SPEC_DIV_ZERO;
            end else if (sgn_a && (req_i.rs1 == {1'b1, {(`MDU_XLEN-1){1'b0}}}) &&
                         (req_i.rs2 == '1)) begin
                spec = SPEC_OVERFLOW;
            end
        end

        prep_d.op       = req_i.op;
        prep_d.mag_a    = neg_a ? -req_i.rs1 : req_i.rs1;
        prep_d.mag_b    = neg_b ? -req_i.rs2 : req_i.rs2;
        prep_d.neg_prod = neg_a ^ neg_b;
        prep_d.neg_q    = neg_a ^ neg_b;
        prep_d.neg_r    = neg_a;               // remainder follows the dividend
        prep_d.spec     = spec;
        prep_d.rs1_raw  = req_i.rs1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            spec_wait_q <= 1'b0;
            spec_q      <= 1'b0;
        end else begin
            mul_start_q <= accept && !req_i.op.div.is_div;
            div_start_q <= accept && req_i.op.div.is_div && (spec == SPEC_NONE);
            spec_wait_q <= accept && (spec != SPEC_NONE);
            spec_q      <= spec_wait_q && !kill_i;   // special path takes one extra cycle
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i || kill_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prep_q <= prep_d;
        end
    end

    assign prep_o      = prep_q;
    assign mul_start_o = mul_start_q;
    assign div_start_o = div_start_q;
    assign spec_o      = spec_q;

    // at most one launch pulse in any cycle
    a_one_launch: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({mul_start_o, div_start_o, spec_o}))
        else $error("more than one launch pulse");

endmodule

// File: source/mdu_params.svh
`ifndef MDU_PARAMS_SVH
`define MDU_PARAMS_SVH

// operand and result width
`define MDU_XLEN 32

// one iteration per operand bit
`define MDU_STEPS `MDU_XLEN

// accept to done_o, through a core
`define MDU_LAT_CORE (`MDU_STEPS + 2)

// accept to done_o, special divide cases
`define MDU_LAT_SPEC 2

`endif

// File: source/mdu_pkg.sv
`include "mdu_params.svh"

package mdu_pkg;

    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mdu_mul_mode_e;

    typedef struct packed {
        logic          is_div;
        mdu_mul_mode_e mode;
    } mdu_mul_view_s;

    typedef struct packed {
        logic is_div;
        logic is_rem;
        logic is_unsigned;
    } mdu_div_view_s;

    // funct3 seen either as a multiply mode or as divide flags
    typedef union packed {
        mdu_mul_view_s mul;
        mdu_div_view_s div;
    } mdu_op_u;

    typedef struct packed {
        mdu_op_u              op;
        logic [`MDU_XLEN-1:0] rs1;
        logic [`MDU_XLEN-1:0] rs2;
    } mdu_req_s;

    typedef enum logic [1:0] {
        SPEC_NONE     = 2'd0,
        SPEC_DIV_ZERO = 2'd1,
        SPEC_OVERFLOW = 2'd2
    } mdu_spec_e;

    typedef struct packed {
        mdu_op_u              op;
        logic [`MDU_XLEN-1:0] mag_a;
        logic [`MDU_XLEN-1:0] mag_b;
        logic                 neg_prod; // negate full product
        logic                 neg_q;
        logic                 neg_r;
        mdu_spec_e            spec;
        logic [`MDU_XLEN-1:0] rs1_raw;  // dividend as given
    } mdu_prep_s;

    typedef struct packed {
        logic [`MDU_XLEN-1:0] hi; // product high / remainder
        logic [`MDU_XLEN-1:0] lo; // product low / quotient
    } mdu_core_res_s;

endpackage

// File: source/mdu_result_fix.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_result_fix import mdu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 kill_i,
    input  mdu_prep_s            prep_i,
    input  logic                 spec_i,
    input  logic                 mul_done_i,
    input  mdu_core_res_s        mul_res_i,
    input  logic                 div_done_i,
    input  mdu_core_res_s        div_res_i,
    output logic                 done_o,
    output logic [`MDU_XLEN-1:0] result_o
);
    logic [2*`MDU_XLEN-1:0] prod;
    logic [2*`MDU_XLEN-1:0] prod_fix;
    logic [`MDU_XLEN-1:0]   mul_word;
    logic [`MDU_XLEN-1:0]   q_fix;
    logic [`MDU_XLEN-1:0]   r_fix;
    logic [`MDU_XLEN-1:0]   div_word;
    logic [`MDU_XLEN-1:0]   spec_word;
    logic [`MDU_XLEN-1:0]   result_d;
    logic [`MDU_XLEN-1:0]   result_q;
    logic                   done_q;

    always_comb begin
        prod     = {mul_res_i.hi, mul_res_i.lo};
        prod_fix = prep_i.neg_prod ? -prod : prod;
        mul_word = (prep_i.op.mul.mode == MUL) ? prod_fix[`MDU_XLEN-1:0]
                                               : prod_fix[2*`MDU_XLEN-1:`MDU_XLEN];

        q_fix    = prep_i.neg_q ? -div_res_i.lo : div_res_i.lo;
        r_fix    = prep_i.neg_r ? -div_res_i.hi : div_res_i.hi;
        div_word = prep_i.op.div.is_rem ? r_fix : q_fix;

        unique case (prep_i.spec)
            SPEC_DIV_ZERO: spec_word = prep_i.op.div.is_rem ? prep_i.rs1_raw : '1;
            SPEC_OVERFLOW: spec_word = prep_i.op.div.is_rem ? '0 : prep_i.rs1_raw;
            default:       spec_word = '0;
        endcase

        if (spec_i) begin
            result_d = spec_word;
        end else if (div_done_i) begin
            result_d = div_word;
        end else begin
            result_d = mul_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= !kill_i && (spec_i || mul_done_i || div_done_i);
        end
    end

    // held until the next completion
    always_ff @(posedge clk) begin
        if (!kill_i && (spec_i || mul_done_i || div_done_i)) begin
            result_q <= result_d;
        end
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

// File: source/mdu_top.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_top import mdu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 kill_i,
    input  mdu_req_s             req_i,
    output logic                 ready_o,
    output logic                 done_o,
    output logic [`MDU_XLEN-1:0] result_o
);
    mdu_prep_s     prep;
    logic          mul_start;
    logic          div_start;
    logic          spec;
    logic          mul_done;
    logic          div_done;
    mdu_core_res_s mul_res;
    mdu_core_res_s div_res;

    mdu_operand_prep prep_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .kill_i      (kill_i),
        .done_i      (done_o),   // frees the input side
        .req_i       (req_i),
        .ready_o     (ready_o),
        .prep_o      (prep),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .spec_o      (spec)
    );

    mdu_multiplier mul_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .kill_i  (kill_i),
        .start_i (mul_start),
        .a_i     (prep.mag_a),
        .b_i     (prep.mag_b),
        .done_o  (mul_done),
        .res_o   (mul_res)
    );

    mdu_divider div_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .kill_i  (kill_i),
        .start_i (div_start),
        .a_i     (prep.mag_a),
        .b_i     (prep.mag_b),
        .done_o  (div_done),
        .res_o   (div_res)
    );

    mdu_result_fix fix_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .kill_i     (kill_i),
        .prep_i     (prep),
        .spec_i     (spec),
        .mul_done_i (mul_done),
        .mul_res_i  (mul_res),
        .div_done_i (div_done),
        .div_res_i  (div_res),
        .done_o     (done_o),
        .result_o   (result_o)
    );

endmodule

// File: src.f
+incdir+source
source/mdu_pkg.sv
source/mdu_operand_prep.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_result_fix.sv
source/mdu_top.sv
verif/mdu_tb.sv

// File: verif/mdu_tb.sv
`timescale 1ns/10ps
`include "mdu_params.svh"

module mdu_tb import mdu_pkg::*; ();

    localparam logic [31:0] SEED      = 32'h456c29ff;
    localparam int          RESET_CYC = 4;
    localparam int          KILL_CYC  = `MDU_LAT_CORE + 12;
    localparam int          N_RANDOM  = 30;

    localparam logic [2:0] OP_MUL    = 3'b000;
    localparam logic [2:0] OP_MULH   = 3'b001;
    localparam logic [2:0] OP_MULHSU = 3'b010;
    localparam logic [2:0] OP_MULHU  = 3'b011;
    localparam logic [2:0] OP_DIV    = 3'b100;
    localparam logic [2:0] OP_DIVU   = 3'b101;
    localparam logic [2:0] OP_REM    = 3'b110;
    localparam logic [2:0] OP_REMU   = 3'b111;

    typedef struct packed {
        logic [2:0]           op;
        logic [`MDU_XLEN-1:0] rs1;
        logic [`MDU_XLEN-1:0] rs2;
        logic [`MDU_XLEN-1:0] res;
    } vec_s;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic                 kill;
    mdu_req_s             req;
    logic                 ready;
    logic                 done;
    logic [`MDU_XLEN-1:0] result;

    vec_s vecs[$];
    vec_s after_kill;
    int   cycles;
    int   limit;
    int   pass_cnt;
    int   fail_cnt;

    mdu_top mdu_top_i (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .start_i  (start),
        .kill_i   (kill),
        .req_i    (req),
        .ready_o  (ready),
        .done_o   (done),
        .result_o (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    // RISC-V M rules on 64-bit arithmetic
    function automatic logic [31:0] ref_result(input logic [2:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        longint      sa;
        longint      sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        logic        ovf;
        logic [31:0] r;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        ua   = {32'd0, a};
        ub   = {32'd0, b};
        p_ss = sa * sb;
        p_su = sa * longint'(ub);
        p_uu = ua * ub;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_MUL:    r = p_ss[31:0];
            OP_MULH:   r = p_ss[63:32];
            OP_MULHSU: r = p_su[63:32];
            OP_MULHU:  r = p_uu[63:32];
            OP_DIV:    r = (b == '0) ? '1 : (ovf ? a : 32'(sa / sb));
            OP_DIVU:   r = (b == '0) ? '1 : a / b;
            OP_REM:    r = (b == '0) ? a : (ovf ? '0 : 32'(sa % sb));
            default:   r = (b == '0) ? a : a % b;
        endcase
        return r;
    endfunction

    function automatic logic is_special(input logic [2:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
        return op[2] && ((b == '0) ||
               (!op[0] && (a == 32'h8000_0000) && (b == 32'hffff_ffff)));
    endfunction

    task automatic add_vec(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] res);
        vecs.push_back({op, a, b, res});
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  op;
        // op, rs1, rs2, expected result
        add_vec(OP_MUL,    32'h0000_0007, 32'hffff_fffd, 32'hffff_ffeb);
        add_vec(OP_MULH,   32'h0000_0007, 32'hffff_fffd, 32'hffff_ffff);
        add_vec(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        add_vec(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_vec(OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_vec(OP_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000);
        add_vec(OP_MUL,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_vec(OP_MULH,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_vec(OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_vec(OP_MULHU,  32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff);
        add_vec(OP_DIV,    32'h0000_0014, 32'h0000_0006, 32'h0000_0003);
        add_vec(OP_DIV,    32'hffff_ffec, 32'h0000_0006, 32'hffff_fffd);
        add_vec(OP_DIV,    32'h0000_0014, 32'hffff_fffa, 32'hffff_fffd);
        add_vec(OP_DIV,    32'hffff_ffec, 32'hffff_fffa, 32'h0000_0003);
        add_vec(OP_REM,    32'h0000_0014, 32'h0000_0006, 32'h0000_0002);
        add_vec(OP_REM,    32'hffff_ffec, 32'h0000_0006, 32'hffff_fffe);
        add_vec(OP_REM,    32'h0000_0014, 32'hffff_fffa, 32'h0000_0002);
        add_vec(OP_REM,    32'hffff_ffec, 32'hffff_fffa, 32'hffff_fffe);
        add_vec(OP_DIVU,   32'hffff_ffec, 32'h0000_0006, 32'h2aaa_aaa7);
        add_vec(OP_REMU,   32'hffff_ffec, 32'h0000_0006, 32'h0000_0002);
        add_vec(OP_DIVU,   32'h0000_0014, 32'hffff_fffa, 32'h0000_0000);
        add_vec(OP_DIV,    32'h0000_1234, 32'h0000_0000, 32'hffff_ffff); // divide by zero
        add_vec(OP_DIVU,   32'h0000_1234, 32'h0000_0000, 32'hffff_ffff);
        add_vec(OP_REM,    32'hffff_ffec, 32'h0000_0000, 32'hffff_ffec);
        add_vec(OP_REMU,   32'h0000_1234, 32'h0000_0000, 32'h0000_1234);
        add_vec(OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000); // signed overflow
        add_vec(OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_vec(OP_REMU,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        for (int i = 0; i < N_RANDOM; i++) begin
            op = 3'(i % 8);
            a  = $urandom;
            b  = (i % 10 == 9) ? '0 : $urandom;
            add_vec(op, a, b, ref_result(op, a, b));
        end
    endtask

    task automatic note_result(input int idx, input string what, input logic ok);
        $display("test %0d %s: %s", idx, what, ok ? "pass" : "fail");
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
    endtask

    task automatic run_op(input int idx, input vec_s v);
        int   lat;
        int   exp_lat;
        logic seen;
        logic ready_low;
        logic ok;
        exp_lat = is_special(v.op, v.rs1, v.rs2) ? `MDU_LAT_SPEC : `MDU_LAT_CORE;
        @(posedge clk);
        while (!ready) begin
            @(posedge clk);
        end
        start <= 1'b1;
        req   <= {v.op, v.rs1, v.rs2};
        @(posedge clk);                          // accept edge
        start <= 1'b0;
        lat       = 0;
        seen      = 1'b0;
        ready_low = 1'b1;
        ok        = 1'b1;
        while (!seen && lat <= `MDU_LAT_CORE + 4) begin
            @(posedge clk);
            if (ready) begin
                ready_low = 1'b0;
            end
            if (done) begin
                seen = 1'b1;
            end else begin
                lat++;
            end
        end
        if (!seen) begin
            $display("test %0d: no done_o came back for the request", idx);
            ok = 1'b0;
        end else begin
            if (result !== v.res) begin
                $display("FAILED at %0t: op %03b rs1 %h rs2 %h gave %h, expected %h",
                         $time, v.op, v.rs1, v.rs2, result, v.res);
                ok = 1'b0;
            end
            if (lat != exp_lat) begin
                $display("FAILED at %0t: latency %0d cycles, expected %0d", $time, lat, exp_lat);
                ok = 1'b0;
            end
        end
        if (!ready_low) begin
            $display("test %0d: ready_o went high while the operation was in flight", idx);
            ok = 1'b0;
        end
        note_result(idx, $sformatf("op %03b rs1 %h rs2 %h", v.op, v.rs1, v.rs2), ok);
    endtask

    task automatic kill_test(input int idx);
        logic ok;
        logic stray_done;
        ok         = 1'b1;
        stray_done = 1'b0;
        @(posedge clk);
        while (!ready) begin
            @(posedge clk);
        end
        start <= 1'b1;
        req   <= {OP_DIV, 32'd1000, 32'd7};
        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(posedge clk);
        kill <= 1'b1;
        @(posedge clk);
        kill <= 1'b0;
        @(posedge clk);                          // first cycle after the kill
        if (!ready) begin
            $display("test %0d: ready_o did not return the cycle after kill_i", idx);
            ok = 1'b0;
        end
        for (int k = 0; k < `MDU_LAT_CORE; k++) begin
            if (done) begin
                stray_done = 1'b1;
            end
            @(posedge clk);
        end
        if (stray_done) begin
            $display("test %0d: done_o was raised for a killed divide", idx);
            ok = 1'b0;
        end
        note_result(idx, "kill during divide", ok);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        kill     = 1'b0;
        req      = '0;
        cycles   = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(SEED));
        build_table();
        limit = RESET_CYC + 2 + KILL_CYC + (vecs.size() + 1) * (`MDU_LAT_CORE + 4);
        after_kill = {OP_MULHU, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        foreach (vecs[i]) begin
            run_op(i, vecs[i]);
        end
        kill_test(vecs.size());
        run_op(vecs.size() + 1, after_kill);
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
